/* src/acc_params.svh */
`ifndef ACC_PARAMS_SVH
`define ACC_PARAMS_SVH

// data path width of host words and xram entries
`define ACC_DATA_W 32

// xram address width
`define ACC_ADDR_W 8

// scratch depth, 2 ** ACC_ADDR_W
`define ACC_DEPTH 256

`endif

/* src/acc_pkg.sv */
`default_nettype none

`include "acc_params.svh"

package acc_pkg;

    typedef logic [`ACC_DATA_W-1:0] data_t;
    typedef logic [`ACC_ADDR_W-1:0] xaddr_t;
    typedef logic [4:0]             fun_t;
    typedef logic [1:0]             op_t;

    // opcodes in command bits 31:30
    localparam op_t OP_XRAM_LD  = 2'd0;
    localparam op_t OP_XRAM_ST  = 2'd1;
    localparam op_t OP_FU_FETCH = 2'd2;
    localparam op_t OP_FU_EX    = 2'd3;

    // other codes pass operand one through
    localparam fun_t FUN_ADD = 5'd0;
    localparam fun_t FUN_SUB = 5'd1;
    localparam fun_t FUN_XOR = 5'd2;
    localparam fun_t FUN_AND = 5'd3;
    localparam fun_t FUN_MAX = 5'd4;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        LD_WAIT,
        ST_READ,
        EX_X1_LD,
        EX_X2_LD,
        EX_START
    } ctrl_state_t;

    typedef struct packed {
        logic   en;
        xaddr_t addr;
        data_t  data;
    } xram_wr_t;

    typedef struct packed {
        logic   fetch;
        fun_t   fun;
        logic   x1_ld;
        logic   x2_ld;
        logic   start;
        xaddr_t wa;
    } eu_ctrl_t;

endpackage

`default_nettype wire

/* src/ctrl_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_unit (
    input  wire               clk,
    input  wire               rst_n,
    input  wire acc_pkg::data_t h2f_io,
    input  wire               h2f_write,
    output acc_pkg::data_t    f2h_io,
    output logic              busy,
    output acc_pkg::xaddr_t   rd_addr,
    input  wire acc_pkg::data_t rd_data,
    output acc_pkg::xram_wr_t host_wr,
    output acc_pkg::eu_ctrl_t eu_ctrl
);
    import acc_pkg::*;

    data_t       cmd_q;
    op_t         op;
    fun_t        fun;
    logic        dual_input;
    xaddr_t      ra1;
    xaddr_t      ra2;
    xaddr_t      wa;
    ctrl_state_t state;
    ctrl_state_t nxt_state;

    // command is held until the sequence ends, wa included for a pending load
    always_ff @(posedge clk) begin
        if (state == IDLE && h2f_write) begin
            cmd_q <= h2f_io;
        end
    end

    assign {op, fun, dual_input, ra1, ra2, wa} = cmd_q;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE: begin
                if (h2f_write) begin
                    nxt_state = DECODE;
                end
            end
            DECODE: begin
                case (op)
                    OP_XRAM_LD:  nxt_state = LD_WAIT;
                    OP_XRAM_ST:  nxt_state = ST_READ;
                    OP_FU_FETCH: nxt_state = IDLE;
                    default:     nxt_state = EX_X1_LD;
                endcase
            end
            LD_WAIT: begin
                // next host strobe carries the data word
                if (h2f_write) begin
                    nxt_state = IDLE;
                end
            end
            ST_READ: begin
                nxt_state = IDLE;
            end
            EX_X1_LD: begin
                nxt_state = dual_input ? EX_X2_LD : EX_START;
            end
            EX_X2_LD: begin
                nxt_state = EX_START;
            end
            default: begin
                nxt_state = IDLE;
            end
        endcase
    end

    // read data for ra1 lands in ST_READ
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            f2h_io <= '0;
        end else if (state == ST_READ) begin
            f2h_io <= rd_data;
        end
    end

    assign busy = (state != IDLE) && (state != LD_WAIT);

    // ra1 issued in DECODE, ra2 while x1 is loaded
    assign rd_addr = (state == EX_X1_LD) ? ra2 : ra1;

    always_comb begin
        host_wr.en   = (state == LD_WAIT) && h2f_write;
        host_wr.addr = wa;
        host_wr.data = h2f_io;
    end

    always_comb begin
        eu_ctrl.fetch = (state == DECODE) && (op == OP_FU_FETCH);
        eu_ctrl.fun   = fun;
        eu_ctrl.x1_ld = (state == EX_X1_LD);
        eu_ctrl.x2_ld = (state == EX_X2_LD);
        eu_ctrl.start = (state == EX_START);
        eu_ctrl.wa    = wa;
    end

endmodule

`default_nettype wire

/* src/xram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_params.svh"

module xram (
    input  wire                     clk,
    input  wire acc_pkg::xaddr_t    rd_addr,
    output acc_pkg::data_t          rd_data,
    input  wire acc_pkg::xram_wr_t  host_wr,
    input  wire acc_pkg::xram_wr_t  fu_wr
);
    import acc_pkg::*;

    data_t mem [`ACC_DEPTH];

    // result write-back beats a host load
    always_ff @(posedge clk) begin
        if (fu_wr.en) begin
            mem[fu_wr.addr] <= fu_wr.data;
        end else if (host_wr.en) begin
            mem[host_wr.addr] <= host_wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire acc_pkg::eu_ctrl_t  eu_ctrl,
    input  wire acc_pkg::data_t     rd_data,
    output acc_pkg::xram_wr_t       fu_wr
);
    import acc_pkg::*;

    fun_t  fun_q;
    data_t x1;
    data_t x2;
    data_t result;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            fun_q <= FUN_ADD;
        end else if (eu_ctrl.fetch) begin
            fun_q <= eu_ctrl.fun;
        end
    end

    // x2 cleared on x1 load so a single-input op sees zero
    always_ff @(posedge clk) begin
        if (eu_ctrl.x1_ld) begin
            x1 <= rd_data;
            x2 <= '0;
        end else if (eu_ctrl.x2_ld) begin
            x2 <= rd_data;
        end
    end

    always_comb begin
        case (fun_q)
            FUN_ADD: result = x1 + x2;
            FUN_SUB: result = x1 - x2;
            FUN_XOR: result = x1 ^ x2;
            FUN_AND: result = x1 & x2;
            // unsigned compare
            FUN_MAX: result = (x1 > x2) ? x1 : x2;
            default: result = x1;
        endcase
    end

    always_comb begin
        fu_wr.en   = eu_ctrl.start;
        fu_wr.addr = eu_ctrl.wa;
        fu_wr.data = result;
    end

endmodule

`default_nettype wire

/* src/acc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire acc_pkg::data_t h2f_io,
    input  wire                 h2f_write,
    output acc_pkg::data_t      f2h_io,
    output wire                 busy,
    output wire                 eu_fetch,
    output wire                 eu_exec
);
    import acc_pkg::*;

    xaddr_t   rd_addr;
    data_t    rd_data;
    xram_wr_t host_wr;
    xram_wr_t fu_wr;
    eu_ctrl_t eu_ctrl;

    ctrl_unit u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .h2f_io    (h2f_io),
        .h2f_write (h2f_write),
        .f2h_io    (f2h_io),
        .busy      (busy),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .host_wr   (host_wr),
        .eu_ctrl   (eu_ctrl)
    );

    xram u_xram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .host_wr (host_wr),
        .fu_wr   (fu_wr)
    );

    exec_unit u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .eu_ctrl (eu_ctrl),
        .rd_data (rd_data),
        .fu_wr   (fu_wr)
    );

    // status pulses for the host
    assign eu_fetch = eu_ctrl.fetch;
    assign eu_exec  = fu_wr.en;

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

/* verification/acc_props.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_props (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        h2f_write,
    input wire                        busy,
    input wire acc_pkg::ctrl_state_t  state,
    input wire acc_pkg::eu_ctrl_t     eu_ctrl
);
    import acc_pkg::*;

    logic [2:0] busy_run;

    // consecutive cycles spent outside IDLE and LD_WAIT
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy_run <= '0;
        end else if (state == IDLE || state == LD_WAIT) begin
            busy_run <= '0;
        end else if (busy_run != 3'd7) begin
            busy_run <= busy_run + 3'd1;
        end
    end

    a_no_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(h2f_write && busy))
        else $error("host write strobe seen while busy");

    // host data must never meet a result write-back
    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(h2f_write && eu_ctrl.start))
        else $error("host write strobe during result write-back");

    // a dual execute is the longest run, four busy cycles
    a_back_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE && state != LD_WAIT) |-> busy_run < 3'd4)
        else $error("control FSM did not return to IDLE within 4 cycles");

endmodule

`default_nettype wire

/* verification/acc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_params.svh"

module acc_tb;
    import acc_pkg::*;

    // command field positions and opcodes
    localparam int OP_LSB   = 30;
    localparam int FUN_LSB  = 25;
    localparam int DUAL_BIT = 24;
    localparam int RA1_LSB  = 16;
    localparam int RA2_LSB  = 8;
    localparam logic [1:0] LD_OP    = 2'd0;
    localparam logic [1:0] ST_OP    = 2'd1;
    localparam logic [1:0] FETCH_OP = 2'd2;
    localparam logic [1:0] EX_OP    = 2'd3;

    localparam int N_STORE = 32;
    localparam int N_RAND  = 400;
    localparam int N_CMDS  = `ACC_DEPTH + N_STORE + 36 + N_RAND;
    localparam int TIMEOUT_CYCLES = 10 * N_CMDS + 100;

    logic  clk;
    logic  rst_n;
    data_t h2f_io;
    logic  h2f_write;
    data_t f2h_io;
    logic  busy;
    logic  eu_fetch;
    logic  eu_exec;

    logic [15:0] lfsr = 16'd7;
    int          errors = 0;
    int          cycles = 0;
    data_t       model_mem [`ACC_DEPTH];
    fun_t        model_fun = FUN_ADD;
    data_t       model_f2h = '0;

    tb_clk_gen u_clk (.clk(clk));

    acc_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .h2f_io    (h2f_io),
        .h2f_write (h2f_write),
        .f2h_io    (f2h_io),
        .busy      (busy),
        .eu_fetch  (eu_fetch),
        .eu_exec   (eu_exec)
    );

    // u_dut.u_ctrl is the only ctrl_unit
    bind ctrl_unit acc_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .h2f_write (h2f_write),
        .busy      (busy),
        .state     (state),
        .eu_ctrl   (eu_ctrl)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic data_t take_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`ACC_DATA_W-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic data_t make_cmd(input logic [1:0] op, input fun_t f, input logic dual,
                                       input xaddr_t ra1, input xaddr_t ra2, input xaddr_t wa);
        return (data_t'(op) << OP_LSB) | (data_t'(f) << FUN_LSB) | (data_t'(dual) << DUAL_BIT)
             | (data_t'(ra1) << RA1_LSB) | (data_t'(ra2) << RA2_LSB) | data_t'(wa);
    endfunction

    // unsigned max, wrapping add and sub, other codes give operand one
    function automatic data_t model_result(input fun_t f, input data_t a, input data_t b);
        case (f)
            FUN_ADD: return a + b;
            FUN_SUB: return a - b;
            FUN_XOR: return a ^ b;
            FUN_AND: return a & b;
            FUN_MAX: return (a >= b) ? a : b;
            default: return a;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_data(input string name, input data_t seen, input data_t exp);
        if (seen !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, seen, exp);
            errors++;
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic seen, input logic exp);
        if (seen !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, seen, exp);
            errors++;
            stop_with_failure();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one command, checked cycle by cycle until busy drops
    task automatic do_cmd(input logic [1:0] op, input fun_t f, input logic dual,
                          input xaddr_t ra1, input xaddr_t ra2, input xaddr_t wa,
                          input data_t ld_data);
        int    lat;
        int    n;
        data_t x1;
        data_t x2;
        x1 = model_mem[ra1];
        x2 = dual ? model_mem[ra2] : '0;
        case (op)
            ST_OP:    lat = 2;
            EX_OP:    lat = dual ? 4 : 3;
            default:  lat = 1;
        endcase
        h2f_io    = make_cmd(op, f, dual, ra1, ra2, wa);
        h2f_write = 1'b1;
        step();
        h2f_write = 1'b0;
        // n counts edges after the strobe edge, n = 0 is DECODE
        n = 0;
        do begin
            if (n > 0) begin
                step();
            end
            check_bit("busy", busy, n < lat);
            check_bit("eu_fetch", eu_fetch, op == FETCH_OP && n == 0);
            check_bit("eu_exec", eu_exec, op == EX_OP && n == lat - 1);
            if (op == ST_OP && n >= lat) begin
                model_f2h = model_mem[ra1];
            end
            check_data("f2h_io", f2h_io, model_f2h);
            n++;
        end while (busy);
        if (op == FETCH_OP) begin
            model_fun = f;
        end
        if (op == EX_OP) begin
            model_mem[wa] = model_result(model_fun, x1, x2);
        end
        if (op == LD_OP) begin
            // data strobe in LD_WAIT
            h2f_io    = ld_data;
            h2f_write = 1'b1;
            step();
            h2f_write = 1'b0;
            check_bit("busy", busy, 1'b0);
            model_mem[wa] = ld_data;
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                stop_with_failure();
            end
        end
    end

    initial begin
        logic [1:0] op;
        fun_t       f;
        logic       dual;
        xaddr_t     r1;
        xaddr_t     r2;
        xaddr_t     w;
        data_t      d;
        rst_n     = 1'b0;
        h2f_io    = '0;
        h2f_write = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("eu_fetch", eu_fetch, 1'b0);
        check_bit("eu_exec", eu_exec, 1'b0);
        check_data("f2h_io", f2h_io, '0);

        // fill every scratch word, then read some back
        for (int i = 0; i < `ACC_DEPTH; i++) begin
            do_cmd(LD_OP, FUN_ADD, 1'b0, '0, '0, xaddr_t'(i), take_bits(32));
        end
        for (int i = 0; i < N_STORE; i++) begin
            do_cmd(ST_OP, FUN_ADD, 1'b0, xaddr_t'(take_bits(8)), '0, '0, '0);
        end

        // five functions and a pass-through code, dual input then single with wa = ra1
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 6; i++) begin
                f  = (i < 5) ? fun_t'(i) : 5'd19;
                r1 = xaddr_t'(take_bits(8));
                r2 = xaddr_t'(take_bits(8));
                w  = (k == 0) ? xaddr_t'(take_bits(8)) : r1;
                do_cmd(FETCH_OP, f, 1'b0, '0, '0, '0, '0);
                do_cmd(EX_OP, FUN_ADD, k == 0, r1, r2, w, '0);
                do_cmd(ST_OP, FUN_ADD, 1'b0, w, '0, '0, '0);
            end
        end

        for (int i = 0; i < N_RAND; i++) begin
            op   = 2'(take_bits(2));
            f    = fun_t'(take_bits(3));
            dual = 1'(take_bits(1));
            r1   = xaddr_t'(take_bits(8));
            r2   = xaddr_t'(take_bits(8));
            w    = xaddr_t'(take_bits(8));
            d    = take_bits(32);
            do_cmd(op, f, dual, r1, r2, w, d);
        end

        if (errors == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/acc_pkg.sv
src/ctrl_unit.sv
src/xram.sv
src/exec_unit.sv
src/acc_top.sv
verification/tb_clk_gen.sv
verification/acc_props.sv
verification/acc_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := acc_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert
SOURCES    := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
